/* edge_detect.f */
hdl/edge_pkg.sv
hdl/edge_wr_if.sv
hdl/rx_frame_buffer.sv
hdl/edge_mapper.sv
hdl/edge_tx_buffer.sv
hdl/edge_top.sv
test/edge_tb.sv

/* Makefile */
# Verilator build of the edge-map testbench

SRCS := hdl/edge_pkg.sv \
        hdl/edge_wr_if.sv \
        hdl/rx_frame_buffer.sv \
        hdl/edge_mapper.sv \
        hdl/edge_tx_buffer.sv \
        hdl/edge_top.sv \
        test/edge_tb.sv

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vedge_tb: $(SRCS) edge_detect.f
	verilator --binary --timing -Wno-fatal --top-module edge_tb -f edge_detect.f

# Exit status of the simulator is the pass or fail result
run: obj_dir/Vedge_tb
	./obj_dir/Vedge_tb

clean:
	rm -rf obj_dir

/* test/edge_tb.sv */
`timescale 1ns/1ps

module edge_tb;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 pix_we;
    edge_pkg::pix_addr_t  pix_addr;
    edge_pkg::pixel_t     pix_data;
    logic                 pix_frame_done;
    logic                 edge_re;
    edge_pkg::edge_byte_t edge_data;
    logic                 edge_frame_ready;
    logic                 busy;

    // Reference image, write order and expected edge map
    edge_pkg::pixel_t     frame     [0:edge_pkg::PIX_COUNT-1];
    int                   order     [0:edge_pkg::PIX_COUNT-1];
    edge_pkg::edge_byte_t exp_bytes [0:edge_pkg::EDGE_BYTES-1];

    always #4 clk = ~clk;  // 8 ns period

    edge_top i_dut (
        .clk              (clk),
        .reset            (reset),
        .pix_we           (pix_we),
        .pix_addr         (pix_addr),
        .pix_data         (pix_data),
        .pix_frame_done   (pix_frame_done),
        .edge_re          (edge_re),
        .edge_data        (edge_data),
        .edge_frame_ready (edge_frame_ready),
        .busy             (busy)
    );

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_edge_byte(input string name, input edge_pkg::edge_byte_t expected,
                                   input edge_pkg::edge_byte_t actual);
        if (actual !== expected) begin
            $display("MISMATCH time %0t: %s expected 8'h%02h, actual 8'h%02h",
                     $time, name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "Edge byte compare failed");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH time %0t: %s expected %b, actual %b",
                     $time, name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "Flag compare failed");
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [7:0] gray_of(input edge_pkg::pixel_t p);
        int sum;
        sum = int'(p.r) + 2 * int'(p.g) + int'(p.b);
        return 8'(sum / 4);
    endfunction

    // Left-neighbour rule, first column never an edge
    task automatic build_model();
        int         row;
        int         col;
        int         diff;
        logic [7:0] g;
        logic [7:0] prev;
        logic [7:0] acc;
        prev = 8'd0;
        acc  = 8'd0;
        for (row = 0; row < edge_pkg::IMG_H; row++) begin
            for (col = 0; col < edge_pkg::IMG_W; col++) begin
                g    = gray_of(frame[row * edge_pkg::IMG_W + col]);
                diff = int'(g) - int'(prev);
                if (diff < 0) begin
                    diff = -diff;
                end
                acc = {acc[6:0], (col != 0) && (diff > int'(edge_pkg::EDGE_THRESH))};
                if (col % 8 == 7) begin
                    exp_bytes[row * edge_pkg::BYTES_PER_ROW + col / 8] = acc;
                end
                prev = g;
            end
        end
    endtask

    task automatic fill_random_frame();
        int          k;
        logic [31:0] raw;
        for (k = 0; k < edge_pkg::PIX_COUNT; k++) begin
            raw      = $urandom;
            frame[k] = raw[23:0];
        end
        build_model();
    endtask

    // Neighbour steps alternate between the threshold and one above it
    task automatic fill_threshold_frame();
        int row;
        int col;
        int base;
        int v;
        for (row = 0; row < edge_pkg::IMG_H; row++) begin
            base = 20 + (row * 37) % 100;  // Row-to-row jump lands on column 0
            for (col = 0; col < edge_pkg::IMG_W; col++) begin
                if (col % 2 == 0) begin
                    v = base;
                end else begin
                    v = base + ((col % 4 == 1) ? 24 : 25);
                end
                // r + b = 2v keeps the gray level exactly v
                frame[row * edge_pkg::IMG_W + col] = {8'(v + 1), 8'(v), 8'(v - 1)};
            end
            // Steps of 24 give 0, steps of 25 give 1
            for (col = 0; col < edge_pkg::BYTES_PER_ROW; col++) begin
                exp_bytes[row * edge_pkg::BYTES_PER_ROW + col] = (col == 0) ? 8'h19 : 8'h99;
            end
        end
    endtask

    ////////////////////////////////////////
    // Host side drivers
    ////////////////////////////////////////

    task automatic write_frame();
        int k;
        int j;
        int tmp;
        int idle;
        for (k = 0; k < edge_pkg::PIX_COUNT; k++) begin
            order[k] = k;
        end
        for (k = edge_pkg::PIX_COUNT - 1; k > 0; k--) begin
            j        = int'($urandom_range(k, 0));
            tmp      = order[k];
            order[k] = order[j];
            order[j] = tmp;
        end
        for (k = 0; k < edge_pkg::PIX_COUNT; k++) begin
            @(negedge clk);
            pix_we   = 1'b1;
            pix_addr = edge_pkg::pix_addr_t'(order[k]);
            pix_data = frame[order[k]];
            if ($urandom_range(7, 0) == 0) begin
                idle = int'($urandom_range(2, 1));
                repeat (idle) begin
                    @(negedge clk);
                    pix_we = 1'b0;
                end
            end
        end
        @(negedge clk);
        pix_we = 1'b0;
    endtask

    task automatic process_frame();
        check_flag("busy", 1'b0, busy);
        pix_frame_done = 1'b1;
        @(negedge clk);
        pix_frame_done = 1'b0;
        @(negedge clk);                     // Mapper start seen on this edge
        check_flag("busy", 1'b1, busy);
        check_flag("edge_frame_ready", 1'b0, edge_frame_ready);
        while (!edge_frame_ready) begin
            @(negedge clk);
        end
        check_flag("busy", 1'b0, busy);
    endtask

    task automatic read_frame();
        int   i;
        int   gap;
        logic exp_ready;
        for (i = 0; i < edge_pkg::EDGE_BYTES; i++) begin
            exp_ready = (i != edge_pkg::EDGE_BYTES - 1);
            check_edge_byte($sformatf("edge_data[%0d]", i), exp_bytes[i], edge_data);
            check_flag("edge_frame_ready", exp_ready, edge_frame_ready);
            gap = int'($urandom_range(2, 0));
            repeat (gap) begin
                @(negedge clk);
                check_edge_byte($sformatf("edge_data[%0d] in gap", i), exp_bytes[i], edge_data);
                check_flag("edge_frame_ready", exp_ready, edge_frame_ready);
            end
            edge_re = 1'b1;
            @(negedge clk);
            edge_re = 1'b0;
        end
        // Counter wrapped back to byte 0
        check_flag("edge_frame_ready", 1'b0, edge_frame_ready);
        check_edge_byte("edge_data[0] after wrap", exp_bytes[0], edge_data);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'h6715));
        reset          = 1'b1;
        pix_we         = 1'b0;
        pix_addr       = '0;
        pix_data       = '0;
        pix_frame_done = 1'b0;
        edge_re        = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_flag("edge_frame_ready", 1'b0, edge_frame_ready);
        check_flag("busy", 1'b0, busy);

        fill_random_frame();
        write_frame();
        process_frame();
        read_frame();

        fill_threshold_frame();
        write_frame();
        process_frame();
        read_frame();

        fill_random_frame();  // Second random frame reuses all counters
        write_frame();
        process_frame();
        read_frame();

        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Three frames at three cycles per pixel plus three per edge byte
    initial begin
        longint limit_ns;
        limit_ns = 3 * (longint'(edge_pkg::PIX_COUNT) * 3
                        + longint'(edge_pkg::EDGE_BYTES) * 3) * 8;
        #(limit_ns);
        $display("Timeout: the edge map run did not finish within %0d ns", limit_ns);
        $display("CHECKS FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* hdl/edge_top.sv */
`timescale 1ns/1ps

module edge_top (
    input  logic                 clk,
    input  logic                 reset,

    // Host pixel write side
    input  logic                 pix_we,
    input  edge_pkg::pix_addr_t  pix_addr,
    input  edge_pkg::pixel_t     pix_data,
    input  logic                 pix_frame_done,

    // Host edge-byte read side
    input  logic                 edge_re,
    output edge_pkg::edge_byte_t edge_data,
    output logic                 edge_frame_ready,

    output logic                 busy
);

    ////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////

    logic                frame_done_d;  // Start strobe for the mapper
    logic                oe;
    edge_pkg::pix_addr_t rd_addr;
    edge_pkg::pixel_t    rd_pixel;

    edge_wr_if i_wr ();

    ////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////

    rx_frame_buffer i_rx_buf (
        .clk            (clk),
        .we             (pix_we),
        .waddr          (pix_addr),
        .wdata          (pix_data),
        .frame_done     (pix_frame_done),
        .oe             (oe),
        .raddr          (rd_addr),
        .rd_pixel       (rd_pixel),
        .frame_done_out (frame_done_d)
    );

    edge_mapper i_mapper (
        .clk      (clk),
        .reset    (reset),
        .start    (frame_done_d),
        .oe       (oe),
        .rd_addr  (rd_addr),
        .rd_pixel (rd_pixel),
        .wr       (i_wr.mapper),
        .busy     (busy)
    );

    edge_tx_buffer i_tx_buf (
        .clk         (clk),
        .reset       (reset),
        .wr          (i_wr.buffer),
        .re          (edge_re),
        .rd_data     (edge_data),
        .frame_ready (edge_frame_ready)
    );

endmodule

/* hdl/edge_tx_buffer.sv */
`timescale 1ns/1ps

module edge_tx_buffer (
    input  logic                 clk,
    input  logic                 reset,

    edge_wr_if.buffer            wr,

    input  logic                 re,
    output edge_pkg::edge_byte_t rd_data,
    output logic                 frame_ready
);

    edge_pkg::edge_byte_t mem [0:edge_pkg::EDGE_BYTES-1];

    edge_pkg::edge_addr_t rd_cnt;  // Host readout position

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Byte at the counter shows up right away
    assign rd_data = mem[rd_cnt];

    ////////////////////////////////////////
    // Readout counter and ready level
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_cnt <= '0;
        end else if (re) begin
            if (rd_cnt == edge_pkg::LAST_EDGE) begin
                rd_cnt <= '0;                  // Back to the start for the next frame
            end else begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // Drops as the counter steps onto the last byte
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_ready <= 1'b0;
        end else if (wr.frame_tick) begin
            frame_ready <= 1'b1;
        end else if (re && (rd_cnt == edge_pkg::LAST_EDGE - 1'b1)) begin
            frame_ready <= 1'b0;
        end
    end

endmodule

/* hdl/edge_mapper.sv */
`timescale 1ns/1ps

module edge_mapper (
    input  logic                clk,
    input  logic                reset,

    input  logic                start,     // Delayed frame-done pulse

    output logic                oe,
    output edge_pkg::pix_addr_t rd_addr,
    input  edge_pkg::pixel_t    rd_pixel,

    edge_wr_if.mapper           wr,

    output logic                busy
);

    // Address sequencer
    logic                 issuing;
    edge_pkg::col_t       col;
    edge_pkg::row_t       row;
    logic                 last_pix;

    // Read stage, lines up with rd_pixel
    logic                 s1_valid;
    logic                 s1_col0;
    logic                 s1_byte_end;
    logic                 s1_last;

    // Gray stage
    logic [9:0]           gray_sum;
    logic                 s2_valid;
    logic                 s2_col0;
    logic                 s2_byte_end;
    logic                 s2_last;
    logic [7:0]           s2_gray;

    // Difference and pack stage
    logic [7:0]           prev_gray;
    logic [7:0]           abs_diff;
    logic                 edge_bit;
    logic [6:0]           bit_sr;    // Older bits of the current byte
    edge_pkg::edge_addr_t byte_cnt;
    logic                 wr_last;

    ////////////////////////////////////////
    // Read address sequencer
    ////////////////////////////////////////

    assign last_pix = (row == edge_pkg::LAST_ROW) && (col == edge_pkg::LAST_COL);
    assign oe       = issuing;

    always_ff @(posedge clk) begin
        if (reset) begin
            issuing <= 1'b0;
            rd_addr <= '0;
            col     <= '0;
            row     <= '0;
        end else if (start) begin
            issuing <= 1'b1;
            rd_addr <= '0;
            col     <= '0;
            row     <= '0;
        end else if (issuing) begin
            rd_addr <= rd_addr + 1'b1;
            if (col == edge_pkg::LAST_COL) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
            if (last_pix) begin
                issuing <= 1'b0;                  // Whole frame issued
            end
        end
    end

    ////////////////////////////////////////
    // Pipeline valids
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issuing;
            s2_valid <= s1_valid;
        end
    end

    // Position flags travel with the data
    always_ff @(posedge clk) begin
        s1_col0     <= (col == '0);
        s1_byte_end <= (col[2:0] == 3'b111);
        s1_last     <= last_pix;
        s2_col0     <= s1_col0;
        s2_byte_end <= s1_byte_end;
        s2_last     <= s1_last;
    end

    ////////////////////////////////////////
    // Gray conversion
    ////////////////////////////////////////

    // (r + 2g + b) / 4, never exceeds 255
    assign gray_sum = {2'b00, rd_pixel.r} + {1'b0, rd_pixel.g, 1'b0} + {2'b00, rd_pixel.b};

    always_ff @(posedge clk) begin
        s2_gray <= gray_sum[9:2];
    end

    ////////////////////////////////////////
    // Neighbour difference and packing
    ////////////////////////////////////////

    assign abs_diff = (s2_gray >= prev_gray) ? (s2_gray - prev_gray) : (prev_gray - s2_gray);
    assign edge_bit = ~s2_col0 && (abs_diff > edge_pkg::EDGE_THRESH);

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            prev_gray <= s2_gray;
            bit_sr    <= {bit_sr[5:0], edge_bit};  // Leftmost pixel ends up in bit 7
        end
        if (s2_valid && s2_byte_end) begin
            wr.data <= {bit_sr, edge_bit};
            wr.addr <= byte_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_cnt      <= '0;
            wr.we         <= 1'b0;
            wr_last       <= 1'b0;
            wr.frame_tick <= 1'b0;
            busy          <= 1'b0;
        end else begin
            wr.we         <= s2_valid && s2_byte_end;
            wr_last       <= s2_valid && s2_last;
            wr.frame_tick <= wr.we && wr_last;
            if (start) begin
                byte_cnt <= '0;
            end else if (s2_valid && s2_byte_end) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            // Busy spans the scan plus pipeline drain
            if (start) begin
                busy <= 1'b1;
            end else if (wr.we && wr_last) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

/* hdl/rx_frame_buffer.sv */
`timescale 1ns/1ps

module rx_frame_buffer (
    input  logic                clk,

    input  logic                we,
    input  edge_pkg::pix_addr_t waddr,
    input  edge_pkg::pixel_t    wdata,
    input  logic                frame_done,

    input  logic                oe,
    input  edge_pkg::pix_addr_t raddr,
    output edge_pkg::pixel_t    rd_pixel,
    output logic                frame_done_out
);

    // One full frame, host order does not matter
    edge_pkg::pixel_t mem [0:edge_pkg::PIX_COUNT-1];

    // Host write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, data valid the cycle after oe
    always_ff @(posedge clk) begin
        if (oe) begin
            rd_pixel <= mem[raddr];
        end
    end

    // Hold back frame_done one cycle behind the final write
    always_ff @(posedge clk) begin
        frame_done_out <= frame_done;
    end

endmodule

/* hdl/edge_wr_if.sv */
`timescale 1ns/1ps

// Edge-byte write port, mapper to transmit buffer
interface edge_wr_if;

    logic                 we;          // One byte per strobe
    edge_pkg::edge_addr_t addr;
    edge_pkg::edge_byte_t data;
    logic                 frame_tick;  // Last byte has been written

    modport mapper (
        output we,
        output addr,
        output data,
        output frame_tick
    );

    modport buffer (
        input we,
        input addr,
        input data,
        input frame_tick
    );

endinterface

/* hdl/edge_pkg.sv */
package edge_pkg;

    ////////////////////////////////////////
    // Image geometry
    ////////////////////////////////////////

    localparam int IMG_W         = 240;
    localparam int IMG_H         = 172;
    localparam int PIX_COUNT     = IMG_W * IMG_H;  // 41280 pixels
    localparam int BYTES_PER_ROW = IMG_W / 8;      // Eight edge bits per byte
    localparam int EDGE_BYTES    = BYTES_PER_ROW * IMG_H;

    // Edge needs a gray step strictly above this
    localparam logic [7:0] EDGE_THRESH = 8'd24;

    ////////////////////////////////////////
    // Address and counter widths
    ////////////////////////////////////////

    localparam int PIX_AW  = $clog2(PIX_COUNT);
    localparam int EDGE_AW = $clog2(EDGE_BYTES);
    localparam int COL_AW  = $clog2(IMG_W);
    localparam int ROW_AW  = $clog2(IMG_H);

    typedef logic [PIX_AW-1:0]  pix_addr_t;
    typedef logic [EDGE_AW-1:0] edge_addr_t;
    typedef logic [COL_AW-1:0]  col_t;
    typedef logic [ROW_AW-1:0]  row_t;

    // Terminal counts for the scan and readout counters
    localparam col_t       LAST_COL  = col_t'(IMG_W - 1);
    localparam row_t       LAST_ROW  = row_t'(IMG_H - 1);
    localparam edge_addr_t LAST_EDGE = edge_addr_t'(EDGE_BYTES - 1);

    ////////////////////////////////////////
    // Data words
    ////////////////////////////////////////

    // RGB888, red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // Bit 7 is the leftmost pixel of the group
    typedef logic [7:0] edge_byte_t;

endpackage
